// File: dmem_pkg.sv
package dmem_pkg;

  // word geometry
  localparam int data_width = 32;
  localparam int mask_width = data_width / 8;

  // default depth of the data memory, in words
  localparam int dmem_els = 1024;
  localparam int dmem_addr_width = $clog2(dmem_els);

  // local byte address carries the two byte-offset bits below the word address
  localparam int byte_addr_width = dmem_addr_width + 2;

  // one data word
  typedef logic [data_width-1:0] data_t;

  // one enable bit per byte lane
  typedef logic [mask_width-1:0] mask_t;

  // word address, as used by the array and the remote port
  typedef logic [dmem_addr_width-1:0] word_addr_t;

  // byte address, as issued by the local core
  typedef logic [byte_addr_width-1:0] byte_addr_t;

  // access size of a local load or store
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } load_size_e;

endpackage

// File: dmem_array.sv
`timescale 1ns/1ps

module dmem_array #(
  parameter int els_p = 1024
) (
  input  logic                clk_i,
  input  logic                reset_i,

  input  logic                v_i,
  input  logic                w_i,
  input  dmem_pkg::word_addr_t addr_i,
  input  dmem_pkg::data_t     data_i,
  input  dmem_pkg::mask_t     mask_i,

  output dmem_pkg::data_t     data_o
);

  // storage organised as byte lanes
  logic [dmem_pkg::mask_width-1:0][7:0] mem_r [els_p];

  // last word read out of the array
  dmem_pkg::data_t data_r;

  logic access;

  // no access is performed while in reset
  assign access = v_i & ~reset_i;

  // masked write, only enabled lanes change
  always_ff @(posedge clk_i) begin
    if (access & w_i) begin
      for (int i = 0; i < dmem_pkg::mask_width; i++) begin
        if (mask_i[i]) begin
          mem_r[addr_i][i] <= data_i[8*i +: 8];
        end
      end
    end
  end

  // synchronous read
  // the output register keeps its word across writes and idle cycles
  always_ff @(posedge clk_i) begin
    if (access & ~w_i) begin
      data_r <= mem_r[addr_i];
    end
  end

  assign data_o = data_r;

endmodule

// File: dmem_access_arbiter.sv
`timescale 1ns/1ps

module dmem_access_arbiter (
  // local core side
  input  logic                    local_v_i,
  input  logic                    local_w_i,
  input  dmem_pkg::byte_addr_t    local_addr_i,
  input  dmem_pkg::load_size_e    local_size_i,
  input  dmem_pkg::data_t         local_data_i,
  input  logic                    local_stall_i,

  // remote network side
  input  logic                    remote_v_i,
  input  logic                    remote_w_i,
  input  dmem_pkg::word_addr_t    remote_addr_i,
  input  dmem_pkg::mask_t         remote_mask_i,
  input  dmem_pkg::data_t         remote_data_i,
  output logic                    remote_yumi_o,

  // array side
  output logic                    mem_v_o,
  output logic                    mem_w_o,
  output dmem_pkg::word_addr_t    mem_addr_o,
  output dmem_pkg::data_t         mem_data_o,
  output dmem_pkg::mask_t         mem_mask_o,

  // to the load return path
  output logic                    local_load_en_o
);

  logic            local_grant;
  dmem_pkg::data_t store_data;
  dmem_pkg::mask_t store_mask;

  // local wins unless the pipeline is stalled
  assign local_grant = local_v_i & ~local_stall_i;

  // replicate sub-word data over the lanes and pick lanes from the offset
  always_comb begin
    case (local_size_i)
      dmem_pkg::size_byte: begin
        store_data = {dmem_pkg::mask_width{local_data_i[7:0]}};
        store_mask = dmem_pkg::mask_t'(1) << local_addr_i[1:0];
      end
      dmem_pkg::size_half: begin
        store_data = {2{local_data_i[15:0]}};
        store_mask = dmem_pkg::mask_t'(3) << {local_addr_i[1], 1'b0};
      end
      default: begin
        store_data = local_data_i;
        store_mask = '1;
      end
    endcase
  end

  always_comb begin
    if (local_grant) begin
      mem_v_o       = 1'b1;
      mem_w_o       = local_w_i;
      mem_addr_o    = local_addr_i[dmem_pkg::byte_addr_width-1:2];
      mem_data_o    = store_data;
      mem_mask_o    = store_mask;
      remote_yumi_o = 1'b0;
    end else begin
      // remote request takes the array, consumed in the same cycle
      mem_v_o       = remote_v_i;
      mem_w_o       = remote_w_i;
      mem_addr_o    = remote_addr_i;
      mem_data_o    = remote_data_i;
      mem_mask_o    = remote_mask_i;
      remote_yumi_o = remote_v_i;
    end
  end

  assign local_load_en_o = local_grant & ~local_w_i;

endmodule

// File: load_return.sv
`timescale 1ns/1ps

module load_return (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  load_en_i,
  input  dmem_pkg::load_size_e  size_i,
  input  logic                  unsigned_i,
  input  logic [1:0]            part_sel_i,

  input  dmem_pkg::data_t       mem_data_i,

  output logic                  load_v_o,
  output dmem_pkg::data_t       load_data_o
);

  logic                 load_en_r;
  dmem_pkg::load_size_e size_r;
  logic                 unsigned_r;
  logic [1:0]           part_sel_r;
  dmem_pkg::data_t      buffer_r;
  dmem_pkg::data_t      word;
  logic [7:0]           byte_sel;
  logic [15:0]          half_sel;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      load_en_r <= 1'b0;
    end else begin
      load_en_r <= load_en_i;
    end
  end

  // load info travels with the enable
  // held until the next local load so the buffered result stays consistent
  always_ff @(posedge clk_i) begin
    if (load_en_i) begin
      size_r     <= size_i;
      unsigned_r <= unsigned_i;
      part_sel_r <= part_sel_i;
    end
  end

  // load buffer, captures the array word in the return cycle
  always_ff @(posedge clk_i) begin
    if (load_en_r) begin
      buffer_r <= mem_data_i;
    end
  end

  // bypass the fresh array output, else the held word
  assign word = load_en_r ? mem_data_i : buffer_r;

  assign byte_sel = word[{part_sel_r, 3'b000} +: 8];
  assign half_sel = word[{part_sel_r[1], 4'b0000} +: 16];

  // pack and extend to a full word
  always_comb begin
    case (size_r)
      dmem_pkg::size_byte: begin
        load_data_o = {{(dmem_pkg::data_width-8){~unsigned_r & byte_sel[7]}}, byte_sel};
      end
      dmem_pkg::size_half: begin
        load_data_o = {{(dmem_pkg::data_width-16){~unsigned_r & half_sel[15]}}, half_sel};
      end
      default: begin
        load_data_o = word;
      end
    endcase
  end

  assign load_v_o = load_en_r;

endmodule

// File: lr_reservation.sv
`timescale 1ns/1ps

module lr_reservation (
  input  logic                 clk_i,
  input  logic                 reset_i,

  // performed array access
  input  logic                 mem_v_i,
  input  logic                 mem_w_i,
  input  dmem_pkg::word_addr_t mem_addr_i,

  // reserving local read, already qualified by the local grant
  input  logic                 reserve_i,

  output logic                 reserved_o
);

  logic                 reserved_r;
  dmem_pkg::word_addr_t reserved_addr_r;
  logic                 make_reservation;
  logic                 break_reservation;

  assign make_reservation  = mem_v_i & ~mem_w_i & reserve_i;

  // any write to the reserved word, local or remote
  assign break_reservation = reserved_r & mem_v_i & mem_w_i
                           & (mem_addr_i == reserved_addr_r);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reserved_r <= 1'b0;
    end else if (make_reservation) begin
      reserved_r <= 1'b1;
    end else if (break_reservation) begin
      reserved_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (make_reservation) begin
      reserved_addr_r <= mem_addr_i;
    end
  end

  assign reserved_o = reserved_r;

endmodule

// File: dmem_tile.sv
`timescale 1ns/1ps

module dmem_tile #(
  parameter int els_p = dmem_pkg::dmem_els
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // local core port
  input  logic                  local_v_i,
  input  logic                  local_w_i,
  input  dmem_pkg::byte_addr_t  local_addr_i,
  input  dmem_pkg::load_size_e  local_size_i,
  input  logic                  local_unsigned_i,
  input  dmem_pkg::data_t       local_data_i,
  input  logic                  local_reserve_i,
  input  logic                  local_stall_i,

  // remote network port, valid/yumi
  input  logic                  remote_v_i,
  input  logic                  remote_w_i,
  input  dmem_pkg::word_addr_t  remote_addr_i,
  input  dmem_pkg::mask_t       remote_mask_i,
  input  dmem_pkg::data_t       remote_data_i,
  output logic                  remote_yumi_o,
  output dmem_pkg::data_t       remote_data_o,

  // local load return
  output logic                  local_load_v_o,
  output dmem_pkg::data_t       local_load_data_o,

  output logic                  reserved_o
);

  logic                 mem_v;
  logic                 mem_w;
  dmem_pkg::word_addr_t mem_addr;
  dmem_pkg::data_t      mem_data_li;
  dmem_pkg::mask_t      mem_mask;
  dmem_pkg::data_t      mem_data_lo;
  logic                 local_load_en;
  logic                 reserve_li;

  // reserve only counts when the local request owns the array
  assign reserve_li = local_reserve_i & local_v_i & ~local_stall_i;

  dmem_access_arbiter arb_i (
    .local_v_i       (local_v_i),
    .local_w_i       (local_w_i),
    .local_addr_i    (local_addr_i),
    .local_size_i    (local_size_i),
    .local_data_i    (local_data_i),
    .local_stall_i   (local_stall_i),
    .remote_v_i      (remote_v_i),
    .remote_w_i      (remote_w_i),
    .remote_addr_i   (remote_addr_i),
    .remote_mask_i   (remote_mask_i),
    .remote_data_i   (remote_data_i),
    .remote_yumi_o   (remote_yumi_o),
    .mem_v_o         (mem_v),
    .mem_w_o         (mem_w),
    .mem_addr_o      (mem_addr),
    .mem_data_o      (mem_data_li),
    .mem_mask_o      (mem_mask),
    .local_load_en_o (local_load_en)
  );

  dmem_array #(
    .els_p (els_p)
  ) dmem_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (mem_v),
    .w_i     (mem_w),
    .addr_i  (mem_addr),
    .data_i  (mem_data_li),
    .mask_i  (mem_mask),
    .data_o  (mem_data_lo)
  );

  // remote reads see the raw array word
  assign remote_data_o = mem_data_lo;

  load_return load_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_en_i   (local_load_en),
    .size_i      (local_size_i),
    .unsigned_i  (local_unsigned_i),
    .part_sel_i  (local_addr_i[1:0]),
    .mem_data_i  (mem_data_lo),
    .load_v_o    (local_load_v_o),
    .load_data_o (local_load_data_o)
  );

  lr_reservation lr_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .mem_v_i    (mem_v),
    .mem_w_i    (mem_w),
    .mem_addr_i (mem_addr),
    .reserve_i  (reserve_li),
    .reserved_o (reserved_o)
  );

endmodule

// File: dmem_tile_sva.sv
`timescale 1ns/1ps

module dmem_tile_sva (
  input logic clk_i,
  input logic reset_i,
  input logic local_v_i,
  input logic local_w_i,
  input logic local_stall_i,
  input logic remote_v_i,
  input logic remote_yumi_i,
  input logic local_load_v_i
);

  logic local_read;

  assign local_read = local_v_i & ~local_w_i & ~local_stall_i;

  // yumi only answers a valid request
  yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) remote_yumi_i |-> remote_v_i
  ) else $error("remote yumi raised without a remote request");

  // an unstalled local request owns the array
  local_blocks_remote: assert property (
    @(posedge clk_i) disable iff (reset_i) (local_v_i & ~local_stall_i) |-> ~remote_yumi_i
  ) else $error("remote yumi raised while a local request holds the array");

  // load return only follows an accepted local read
  load_v_after_read: assert property (
    @(posedge clk_i) disable iff (reset_i) local_load_v_i |-> $past(local_read)
  ) else $error("local load valid without an accepted read in the cycle before");

endmodule

bind dmem_tile dmem_tile_sva sva_i (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .local_v_i      (local_v_i),
  .local_w_i      (local_w_i),
  .local_stall_i  (local_stall_i),
  .remote_v_i     (remote_v_i),
  .remote_yumi_i  (remote_yumi_o),
  .local_load_v_i (local_load_v_o)
);

// File: tb_dmem_tile.sv
`timescale 1ns/1ps

module tb_dmem_tile;

  // random traffic stays inside a window that test 1 fills first
  localparam int win_words = 64;
  localparam dmem_pkg::word_addr_t win_base = 10'h180;
  localparam int cycles_per_test = 500;
  // four long tests plus margin for reset and the short reset test
  localparam int timeout_cycles = 4 * cycles_per_test + 500;

  logic                 clk_i;
  logic                 reset_i;
  logic                 local_v_i;
  logic                 local_w_i;
  dmem_pkg::byte_addr_t local_addr_i;
  dmem_pkg::load_size_e local_size_i;
  logic                 local_unsigned_i;
  dmem_pkg::data_t      local_data_i;
  logic                 local_reserve_i;
  logic                 local_stall_i;
  logic                 remote_v_i;
  logic                 remote_w_i;
  dmem_pkg::word_addr_t remote_addr_i;
  dmem_pkg::mask_t      remote_mask_i;
  dmem_pkg::data_t      remote_data_i;
  logic                 remote_yumi_o;
  dmem_pkg::data_t      remote_data_o;
  logic                 local_load_v_o;
  dmem_pkg::data_t      local_load_data_o;
  logic                 reserved_o;

  integer seed;
  int     errors;
  int     test_errors;
  int     checks;
  int     cycle_count;
  logic   remote_taken;

  // byte shadow of the memory and the expected outputs
  logic [7:0]           shadow [dmem_pkg::dmem_els*4];
  logic                 exp_load_v;
  dmem_pkg::data_t      exp_load_data;
  logic                 load_known;
  logic                 rdata_known;
  dmem_pkg::data_t      exp_rdata;
  logic                 exp_reserved;
  dmem_pkg::word_addr_t resv_addr;

  dmem_tile dut_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .local_v_i         (local_v_i),
    .local_w_i         (local_w_i),
    .local_addr_i      (local_addr_i),
    .local_size_i      (local_size_i),
    .local_unsigned_i  (local_unsigned_i),
    .local_data_i      (local_data_i),
    .local_reserve_i   (local_reserve_i),
    .local_stall_i     (local_stall_i),
    .remote_v_i        (remote_v_i),
    .remote_w_i        (remote_w_i),
    .remote_addr_i     (remote_addr_i),
    .remote_mask_i     (remote_mask_i),
    .remote_data_i     (remote_data_i),
    .remote_yumi_o     (remote_yumi_o),
    .remote_data_o     (remote_data_o),
    .local_load_v_o    (local_load_v_o),
    .local_load_data_o (local_load_data_o),
    .reserved_o        (reserved_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic dmem_pkg::word_addr_t rnd_word();
    return win_base + dmem_pkg::word_addr_t'(rnd(win_words));
  endfunction

  function automatic dmem_pkg::data_t shadow_word(input dmem_pkg::word_addr_t w);
    return {shadow[4*w+3], shadow[4*w+2], shadow[4*w+1], shadow[4*w]};
  endfunction

  // sign or zero extension of the addressed bytes
  function automatic dmem_pkg::data_t expected_load(input dmem_pkg::byte_addr_t a,
                                                    input dmem_pkg::load_size_e sz,
                                                    input logic uns);
    logic [7:0]  b;
    logic [15:0] h;
    b = shadow[a];
    h = {shadow[a+1], shadow[a]};
    case (sz)
      dmem_pkg::size_byte: return {{24{b[7] & ~uns}}, b};
      dmem_pkg::size_half: return {{16{h[15] & ~uns}}, h};
      default: return shadow_word(a[dmem_pkg::byte_addr_width-1:2]);
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic store_local(input dmem_pkg::byte_addr_t a, input dmem_pkg::load_size_e sz,
                             input dmem_pkg::data_t d);
    case (sz)
      dmem_pkg::size_byte: shadow[a] = d[7:0];
      dmem_pkg::size_half: begin
        shadow[a]   = d[7:0];
        shadow[a+1] = d[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) shadow[{a[11:2], 2'b00} + i] = d[8*i +: 8];
      end
    endcase
  endtask

  // a write to the reserved word breaks the reservation
  task automatic note_write(input dmem_pkg::word_addr_t w);
    if (exp_reserved && w == resv_addr) exp_reserved = 1'b0;
  endtask

  task automatic note_read(input dmem_pkg::word_addr_t w, input logic reserve);
    exp_rdata   = shadow_word(w);
    rdata_known = 1'b1;
    if (reserve) begin
      exp_reserved = 1'b1;
      resv_addr    = w;
    end
  endtask

  // check mid-cycle, record the accepted access, then move to the next cycle
  task automatic run_cycle();
    logic grant;
    dmem_pkg::word_addr_t w;
    #4;
    grant = local_v_i & ~local_stall_i;
    check_value("remote_yumi_o", remote_yumi_o, remote_v_i & ~grant);
    check_value("local_load_v_o", local_load_v_o, exp_load_v);
    // the packed result stays until the next local load
    if (load_known) check_value("local_load_data_o", local_load_data_o, exp_load_data);
    if (rdata_known) check_value("remote_data_o", remote_data_o, exp_rdata);
    check_value("reserved_o", reserved_o, exp_reserved);
    exp_load_v   = 1'b0;
    remote_taken = remote_yumi_o;
    if (grant) begin
      w = local_addr_i[dmem_pkg::byte_addr_width-1:2];
      if (local_w_i) begin
        store_local(local_addr_i, local_size_i, local_data_i);
        note_write(w);
      end else begin
        exp_load_v    = 1'b1;
        load_known    = 1'b1;
        exp_load_data = expected_load(local_addr_i, local_size_i, local_unsigned_i);
        note_read(w, local_reserve_i);
      end
    end else if (remote_yumi_o) begin
      if (remote_w_i) begin
        for (int i = 0; i < 4; i++) begin
          if (remote_mask_i[i]) shadow[4*remote_addr_i + i] = remote_data_i[8*i +: 8];
        end
        note_write(remote_addr_i);
      end else begin
        note_read(remote_addr_i, 1'b0);
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_inputs();
    local_v_i       = 1'b0;
    local_reserve_i = 1'b0;
    local_stall_i   = 1'b0;
    remote_v_i      = 1'b0;
  endtask

  task automatic drive_remote(input logic wr, input dmem_pkg::word_addr_t w,
                              input dmem_pkg::mask_t m);
    remote_v_i    = 1'b1;
    remote_w_i    = wr;
    remote_addr_i = w;
    remote_mask_i = m;
    remote_data_i = $random(seed);
  endtask

  // naturally aligned offset for the random size
  task automatic drive_local(input logic wr, input dmem_pkg::word_addr_t w, input logic rsv);
    int unsigned sz;
    sz               = rnd(3);
    local_v_i        = 1'b1;
    local_w_i        = wr;
    local_size_i     = dmem_pkg::load_size_e'(sz);
    local_unsigned_i = 1'(rnd(2));
    local_data_i     = $random(seed);
    local_reserve_i  = rsv;
    case (sz)
      0: local_addr_i = {w, 2'(rnd(4))};
      1: local_addr_i = {w, 1'(rnd(2)), 1'b0};
      default: local_addr_i = {w, 2'b00};
    endcase
  endtask

  // a held load keeps the local port busy for the whole reset
  task automatic apply_reset(input logic hold_load);
    reset_i = 1'b1;
    if (!hold_load) idle_inputs();
    repeat (8) @(posedge clk_i);
    #1;
    reset_i      = 1'b0;
    idle_inputs();
    exp_load_v   = 1'b0;
    exp_reserved = 1'b0;
    load_known   = 1'b0;
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  initial begin
    dmem_pkg::word_addr_t w;
    dmem_pkg::word_addr_t other;
    seed             = 32'hb11f;
    errors           = 0;
    test_errors      = 0;
    checks           = 0;
    rdata_known      = 1'b0;
    exp_load_v       = 1'b0;
    load_known       = 1'b0;
    exp_reserved     = 1'b0;
    local_w_i        = 1'b0;
    local_addr_i     = '0;
    local_size_i     = dmem_pkg::size_word;
    local_unsigned_i = 1'b0;
    local_data_i     = '0;
    remote_w_i       = 1'b0;
    remote_addr_i    = '0;
    remote_mask_i    = '0;
    remote_data_i    = '0;
    apply_reset(1'b0);

    // remote fill of the window, then masked writes and reads
    for (int i = 0; i < win_words; i++) begin
      drive_remote(1'b1, win_base + dmem_pkg::word_addr_t'(i), '1);
      run_cycle();
    end
    repeat (150) begin
      if (rnd(2) != 0) drive_remote(1'b1, rnd_word(), dmem_pkg::mask_t'(rnd(16)));
      else drive_remote(1'b0, rnd_word(), '1);
      run_cycle();
    end
    idle_inputs();
    run_cycle();
    report_test("remote_access");

    // local stores and loads of every size, with idle gaps
    repeat (200) begin
      idle_inputs();
      case (rnd(4))
        0: drive_local(1'b1, rnd_word(), 1'b0);
        1, 2: drive_local(1'b0, rnd_word(), 1'b0);
        default: ;
      endcase
      run_cycle();
    end
    idle_inputs();
    run_cycle();
    report_test("local_access");

    // held remote request against random local traffic and stalls
    repeat (60) begin
      idle_inputs();
      drive_remote(1'(rnd(2)), rnd_word(), dmem_pkg::mask_t'(rnd(16)));
      do begin
        if (rnd(3) != 0) drive_local(1'(rnd(2)), rnd_word(), 1'b0);
        else local_v_i = 1'b0;
        local_stall_i = 1'(rnd(2));
        run_cycle();
      end while (!remote_taken);
    end
    idle_inputs();
    run_cycle();
    report_test("arbitration");

    // reserve a word, write around it, then write it
    repeat (40) begin
      idle_inputs();
      w = rnd_word();
      drive_local(1'b0, w, 1'b1);
      run_cycle();
      idle_inputs();
      run_cycle();
      repeat (3) begin
        other = rnd_word();
        if (other == w) other = w + 1'b1;
        idle_inputs();
        if (rnd(2) != 0) drive_local(1'b1, other, 1'b0);
        else drive_remote(1'b1, other, '1);
        run_cycle();
      end
      idle_inputs();
      if (rnd(2) != 0) drive_local(1'b1, w, 1'b0);
      else drive_remote(1'b1, w, dmem_pkg::mask_t'(rnd(15) + 1));
      run_cycle();
      idle_inputs();
      run_cycle();
      run_cycle();
    end
    report_test("reservation");

    // reset with a reservation and a load return in flight
    idle_inputs();
    drive_local(1'b0, rnd_word(), 1'b1);
    run_cycle();
    drive_local(1'b0, rnd_word(), 1'b0);
    run_cycle();
    // a reserving load stays on the port through reset
    drive_local(1'b0, rnd_word(), 1'b1);
    apply_reset(1'b1);
    repeat (20) begin
      idle_inputs();
      if (rnd(2) != 0) drive_remote(1'(rnd(2)), rnd_word(), dmem_pkg::mask_t'(rnd(16)));
      run_cycle();
    end
    report_test("after_reset");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: dmem_tile.f
dmem_pkg.sv
dmem_array.sv
dmem_access_arbiter.sv
load_return.sv
lr_reservation.sv
dmem_tile.sv
dmem_tile_sva.sv
tb_dmem_tile.sv

// File: Bender.yml
package:
  name: dmem_tile

sources:
  - dmem_pkg.sv
  - dmem_array.sv
  - dmem_access_arbiter.sv
  - load_return.sv
  - lr_reservation.sv
  - dmem_tile.sv
  - target: test
    files:
      - dmem_tile_sva.sv
      - tb_dmem_tile.sv
